// File: consolite_pkg.sv
// Consolite core definitions
// Widths, instruction opcodes, status codes, condition flags and the
// controller state encoding shared by all blocks of the CPU core

package consolite_pkg;

   localparam int word_bits   = 16;
   localparam int addr_bits   = 16;
   localparam int instr_bits  = 32;
   localparam int instr_bytes = 4;
   localparam int num_regs    = 16;
   localparam int status_bits = 12;

   typedef logic [word_bits-1:0]        word_t;
   typedef logic [addr_bits-1:0]        addr_t;
   typedef logic [instr_bits-1:0]       instr_t;
   typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

   localparam logic [status_bits-1:0] status_default      = 12'h000;
   // OR'd with the offending opcode
   localparam logic [status_bits-1:0] status_invalid_base = 12'h800;

   // Numbered from zero with no holes, so op_jns is the highest legal code
   typedef enum logic [7:0] {
      op_nop, op_load, op_loadi, op_mov, op_movi,
      op_add, op_sub, op_and, op_or, op_xor,
      op_shl, op_shra, op_shrl, op_cmp, op_tst,
      op_stor, op_stori,
      op_jmp, op_jmpi,
      op_jeq, op_jne, op_jg, op_jge, op_ja, op_jae,
      op_jl, op_jle, op_jb, op_jbe, op_jo, op_jno,
      op_js, op_jns
   } opcode_t;

   typedef struct packed {
      logic overflow;
      logic carry;
      logic zero;
      logic sign;
   } flags_t;

   typedef enum logic [2:0] {
      st_pre_boot,
      st_executing,
      st_wr_wait,
      st_rd_wait,
      st_halt
   } ctrl_state_t;

endpackage

// File: register_file.sv
// General purpose register file
// Sixteen words, two combinational read ports, one synchronous write port

`timescale 1ns/1ps

module register_file (
   input  logic                    clk,
   input  logic                    rst_n,
   input  consolite_pkg::reg_idx_t rd_idx_a,
   input  consolite_pkg::reg_idx_t rd_idx_b,
   output consolite_pkg::word_t    rd_data_a,
   output consolite_pkg::word_t    rd_data_b,
   input  logic                    wr_en,
   input  consolite_pkg::reg_idx_t wr_idx,
   input  consolite_pkg::word_t    wr_data
);

   consolite_pkg::word_t regs [consolite_pkg::num_regs];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < consolite_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];

   // Write index comes from the control FSM, either decode or saved load target
   a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_idx));

endmodule

// File: alu.sv
// Consolite ALU
// Register-register arithmetic, logic and shifts with next flag values.
// Works over a 17-bit value so the carry out of bit 15 is kept.

`timescale 1ns/1ps

module alu (
   input  consolite_pkg::opcode_t opcode,
   input  consolite_pkg::word_t   dest,
   input  consolite_pkg::word_t   src,
   output consolite_pkg::word_t   result,
   output consolite_pkg::flags_t  flags_next
);

   localparam int msb = consolite_pkg::word_bits - 1;

   logic [consolite_pkg::word_bits:0] wide;
   consolite_pkg::word_t              shra_val;

   // Signed operand so the shift fills with the sign bit
   assign shra_val = $signed(dest) >>> src;

   always_comb begin
      case (opcode)
         consolite_pkg::op_add:  wide = {1'b0, dest} + {1'b0, src};
         consolite_pkg::op_sub,
         consolite_pkg::op_cmp:  wide = {1'b0, dest} - {1'b0, src};
         consolite_pkg::op_and,
         consolite_pkg::op_tst:  wide = {1'b0, dest & src};
         consolite_pkg::op_or:   wide = {1'b0, dest | src};
         consolite_pkg::op_xor:  wide = {1'b0, dest ^ src};
         consolite_pkg::op_shl:  wide = {1'b0, dest << src};
         consolite_pkg::op_shra: wide = {1'b0, shra_val};
         consolite_pkg::op_shrl: wide = {1'b0, dest >> src};
         default:                wide = '0;
      endcase
   end

   assign result = wide[msb:0];

   always_comb begin
      // Same-sign operands giving an opposite-sign sum
      if (opcode == consolite_pkg::op_add) begin
         flags_next.overflow = (dest[msb] & src[msb] & ~wide[msb]) |
                               (~dest[msb] & ~src[msb] & wide[msb]);
      // Negative minus positive giving positive, or the reverse
      end else if (opcode == consolite_pkg::op_sub ||
                   opcode == consolite_pkg::op_cmp) begin
         flags_next.overflow = (dest[msb] & ~src[msb] & ~wide[msb]) |
                               (~dest[msb] & src[msb] & wide[msb]);
      end else begin
         flags_next.overflow = 1'b0;
      end
      flags_next.carry = wide[consolite_pkg::word_bits];
      flags_next.zero  = (wide[msb:0] == '0);
      flags_next.sign  = wide[msb];
   end

endmodule

// File: flag_unit.sv
// Condition flag register and branch decision
// Flags follow ADD, SUB, CMP and TST and clear on every other instruction

`timescale 1ns/1ps

module flag_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   accept,
   input  consolite_pkg::opcode_t opcode,
   input  consolite_pkg::flags_t  flags_next,
   output logic                   branch_taken
);

   consolite_pkg::flags_t flags_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flags_q <= '0;
      end else if (accept) begin
         case (opcode)
            consolite_pkg::op_add, consolite_pkg::op_sub,
            consolite_pkg::op_cmp, consolite_pkg::op_tst: flags_q <= flags_next;
            default:                                      flags_q <= '0;
         endcase
      end
   end

   // Jump conditions, evaluated on the flags left by the previous instruction
   always_comb begin
      case (opcode)
         consolite_pkg::op_jmp,
         consolite_pkg::op_jmpi: branch_taken = 1'b1;
         consolite_pkg::op_jeq:  branch_taken = flags_q.zero;
         consolite_pkg::op_jne:  branch_taken = !flags_q.zero;
         consolite_pkg::op_jg:   branch_taken = !flags_q.zero && (flags_q.sign == flags_q.overflow);
         consolite_pkg::op_jge:  branch_taken = (flags_q.sign == flags_q.overflow);
         consolite_pkg::op_ja:   branch_taken = !flags_q.carry && !flags_q.zero;
         consolite_pkg::op_jae:  branch_taken = !flags_q.carry;
         consolite_pkg::op_jl:   branch_taken = (flags_q.sign != flags_q.overflow);
         consolite_pkg::op_jle:  branch_taken = (flags_q.sign != flags_q.overflow) || flags_q.zero;
         consolite_pkg::op_jb:   branch_taken = flags_q.carry;
         consolite_pkg::op_jbe:  branch_taken = flags_q.carry || flags_q.zero;
         consolite_pkg::op_jo:   branch_taken = flags_q.overflow;
         consolite_pkg::op_jno:  branch_taken = !flags_q.overflow;
         consolite_pkg::op_js:   branch_taken = flags_q.sign;
         consolite_pkg::op_jns:  branch_taken = !flags_q.sign;
         default:                branch_taken = 1'b0;
      endcase
   end

endmodule

// File: control_unit.sv
// Consolite control unit
// Boot and execute FSM, instruction decode, instruction pointer,
// data cache strobes, register write-back and halt on unknown opcodes

`timescale 1ns/1ps

module control_unit (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   boot_done,
   input  logic                                   instr_valid,
   input  consolite_pkg::instr_t                  cur_instr,
   output consolite_pkg::addr_t                   instr_ptr,
   output logic [consolite_pkg::status_bits-1:0]  status,
   output logic                                   cache_wr_en,
   output consolite_pkg::addr_t                   cache_wr_addr,
   output consolite_pkg::word_t                   cache_wr_data,
   input  logic                                   cache_wr_done,
   output logic                                   cache_rd_en,
   output consolite_pkg::addr_t                   cache_rd_addr,
   input  consolite_pkg::word_t                   cache_rd_data,
   input  logic                                   cache_rd_done,
   output consolite_pkg::opcode_t                 opcode,
   output consolite_pkg::reg_idx_t                rd_idx_a,
   output consolite_pkg::reg_idx_t                rd_idx_b,
   input  consolite_pkg::word_t                   dest,
   input  consolite_pkg::word_t                   src,
   input  consolite_pkg::word_t                   alu_result,
   output logic                                   accept,
   input  logic                                   branch_taken,
   output logic                                   reg_wr_en,
   output consolite_pkg::reg_idx_t                reg_wr_idx,
   output consolite_pkg::word_t                   reg_wr_data
);

   consolite_pkg::ctrl_state_t state;
   consolite_pkg::reg_idx_t    reg1;
   consolite_pkg::reg_idx_t    load_reg;
   consolite_pkg::word_t       arg_a;
   consolite_pkg::word_t       arg_b;
   consolite_pkg::addr_t       next_ptr;
   logic wr_req, rd_req, wr_issue, rd_issue, stall, invalid, rd_finish;

   // Field decode
   assign opcode   = consolite_pkg::opcode_t'(cur_instr[31:24]);
   assign reg1     = cur_instr[19:16];
   assign rd_idx_a = reg1;
   assign rd_idx_b = cur_instr[11:8];
   assign arg_a    = cur_instr[23:8];
   assign arg_b    = cur_instr[15:0];

   assign accept  = (state == consolite_pkg::st_executing) && instr_valid;
   // Opcodes are contiguous, anything past the last jump is unknown
   assign invalid = accept && (cur_instr[31:24] > 8'(consolite_pkg::op_jns));

   assign wr_req   = accept && (opcode == consolite_pkg::op_stor ||
                                opcode == consolite_pkg::op_stori);
   assign rd_req   = accept && (opcode == consolite_pkg::op_load ||
                                opcode == consolite_pkg::op_loadi);
   assign wr_issue = wr_req && cache_wr_done;
   assign rd_issue = rd_req && cache_rd_done;
   // Cache busy, retry the same instruction
   assign stall    = (wr_req && !cache_wr_done) || (rd_req && !cache_rd_done);

   // The cycle carrying the strobe never ends a wait, done may still be high then
   assign rd_finish = (state == consolite_pkg::st_rd_wait) && cache_rd_done && !cache_rd_en;

   // JMP takes its target from a register, the other jumps from arg_a
   always_comb begin
      if (!branch_taken) begin
         next_ptr = instr_ptr + consolite_pkg::addr_t'(consolite_pkg::instr_bytes);
      end else if (opcode == consolite_pkg::op_jmp) begin
         next_ptr = dest;
      end else begin
         next_ptr = arg_a;
      end
   end

   // Register write source
   always_comb begin
      reg_wr_en   = 1'b0;
      reg_wr_idx  = reg1;
      reg_wr_data = alu_result;
      if (rd_finish) begin
         reg_wr_en   = 1'b1;
         reg_wr_idx  = load_reg;
         reg_wr_data = cache_rd_data;
      end else if (accept) begin
         case (opcode)
            consolite_pkg::op_mov: begin
               reg_wr_en   = 1'b1;
               reg_wr_data = src;
            end
            consolite_pkg::op_movi: begin
               reg_wr_en   = 1'b1;
               reg_wr_data = arg_b;
            end
            consolite_pkg::op_add, consolite_pkg::op_sub, consolite_pkg::op_and,
            consolite_pkg::op_or, consolite_pkg::op_xor, consolite_pkg::op_shl,
            consolite_pkg::op_shra, consolite_pkg::op_shrl: reg_wr_en = 1'b1;
            default: reg_wr_en = 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= consolite_pkg::st_pre_boot;
         instr_ptr   <= '0;
         status      <= consolite_pkg::status_default;
         cache_wr_en <= 1'b0;
         cache_rd_en <= 1'b0;
      end else begin
         // Strobes are single-cycle pulses
         cache_wr_en <= 1'b0;
         cache_rd_en <= 1'b0;
         case (state)
            consolite_pkg::st_pre_boot: begin
               if (boot_done) begin
                  state <= consolite_pkg::st_executing;
               end
            end
            consolite_pkg::st_executing: begin
               if (invalid) begin
                  status <= consolite_pkg::status_invalid_base | {4'h0, cur_instr[31:24]};
                  state  <= consolite_pkg::st_halt;
               end else if (accept && !stall) begin
                  instr_ptr <= next_ptr;
                  if (wr_issue) begin
                     cache_wr_en <= 1'b1;
                     state       <= consolite_pkg::st_wr_wait;
                  end else if (rd_issue) begin
                     cache_rd_en <= 1'b1;
                     state       <= consolite_pkg::st_rd_wait;
                  end
               end
            end
            consolite_pkg::st_wr_wait: begin
               if (cache_wr_done && !cache_wr_en) begin
                  state <= consolite_pkg::st_executing;
               end
            end
            consolite_pkg::st_rd_wait: begin
               if (rd_finish) begin
                  state <= consolite_pkg::st_executing;
               end
            end
            default: state <= consolite_pkg::st_halt;
         endcase
      end
   end

   // Cache address and data, plus the load target held through the wait
   always_ff @(posedge clk) begin
      if (wr_issue) begin
         cache_wr_data <= dest;
         cache_wr_addr <= (opcode == consolite_pkg::op_stori) ? arg_b : src;
      end
      if (rd_issue) begin
         cache_rd_addr <= (opcode == consolite_pkg::op_loadi) ? arg_b : src;
         load_reg      <= reg1;
      end
   end

   a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
      (cache_rd_en || cache_wr_en) |=> !(cache_rd_en || cache_wr_en));

   a_wr_en_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
      cache_wr_en |-> $past(cache_wr_done));

   a_rd_en_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
      cache_rd_en |-> $past(cache_rd_done));

   a_halt_ptr_fixed: assert property (@(posedge clk) disable iff (!rst_n)
      (state == consolite_pkg::st_halt) |=> $stable(instr_ptr));

endmodule

// File: processor.sv
// Consolite processor core top level
// Joins the control unit, register file, ALU and flag unit and exposes
// the boot, status, instruction fetch and data cache ports

`timescale 1ns/1ps

module processor (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   boot_done,
   output logic [consolite_pkg::status_bits-1:0]  status,
   output consolite_pkg::addr_t                   instr_ptr,
   input  logic                                   instr_valid,
   input  consolite_pkg::instr_t                  cur_instr,
   output logic                                   cache_wr_en,
   output consolite_pkg::addr_t                   cache_wr_addr,
   output consolite_pkg::word_t                   cache_wr_data,
   input  logic                                   cache_wr_done,
   output logic                                   cache_rd_en,
   output consolite_pkg::addr_t                   cache_rd_addr,
   input  consolite_pkg::word_t                   cache_rd_data,
   input  logic                                   cache_rd_done
);

   consolite_pkg::opcode_t  opcode;
   consolite_pkg::reg_idx_t rd_idx_a;
   consolite_pkg::reg_idx_t rd_idx_b;
   consolite_pkg::word_t    dest;
   consolite_pkg::word_t    src;
   consolite_pkg::word_t    alu_result;
   consolite_pkg::flags_t   flags_next;
   logic                    accept;
   logic                    branch_taken;
   logic                    reg_wr_en;
   consolite_pkg::reg_idx_t reg_wr_idx;
   consolite_pkg::word_t    reg_wr_data;

   control_unit i_control_unit (
      .clk           (clk),
      .rst_n         (rst_n),
      .boot_done     (boot_done),
      .instr_valid   (instr_valid),
      .cur_instr     (cur_instr),
      .instr_ptr     (instr_ptr),
      .status        (status),
      .cache_wr_en   (cache_wr_en),
      .cache_wr_addr (cache_wr_addr),
      .cache_wr_data (cache_wr_data),
      .cache_wr_done (cache_wr_done),
      .cache_rd_en   (cache_rd_en),
      .cache_rd_addr (cache_rd_addr),
      .cache_rd_data (cache_rd_data),
      .cache_rd_done (cache_rd_done),
      .opcode        (opcode),
      .rd_idx_a      (rd_idx_a),
      .rd_idx_b      (rd_idx_b),
      .dest          (dest),
      .src           (src),
      .alu_result    (alu_result),
      .accept        (accept),
      .branch_taken  (branch_taken),
      .reg_wr_en     (reg_wr_en),
      .reg_wr_idx    (reg_wr_idx),
      .reg_wr_data   (reg_wr_data)
   );

   register_file i_register_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (dest),
      .rd_data_b (src),
      .wr_en     (reg_wr_en),
      .wr_idx    (reg_wr_idx),
      .wr_data   (reg_wr_data)
   );

   alu i_alu (
      .opcode     (opcode),
      .dest       (dest),
      .src        (src),
      .result     (alu_result),
      .flags_next (flags_next)
   );

   flag_unit i_flag_unit (
      .clk          (clk),
      .rst_n        (rst_n),
      .accept       (accept),
      .opcode       (opcode),
      .flags_next   (flags_next),
      .branch_taken (branch_taken)
   );

endmodule

// File: tb_processor.sv
// Consolite processor testbench
// Runs a generated program from an instruction ROM against a data cache
// model with random latency, and checks the core with concurrent
// assertions against a reference model of registers, flags and memory

`timescale 1ns/1ps

module tb_processor;

   localparam int max_cycles = 20000;
   localparam int rom_words  = 1024;

   logic        clk;
   logic        rst_n;
   logic        boot_done;
   logic [11:0] status;
   logic [15:0] instr_ptr;
   logic        instr_valid;
   logic [31:0] cur_instr;
   logic        cache_wr_en;
   logic [15:0] cache_wr_addr;
   logic [15:0] cache_wr_data;
   logic        cache_wr_done;
   logic        cache_rd_en;
   logic [15:0] cache_rd_addr;
   logic [15:0] cache_rd_data;
   logic        cache_rd_done;

   int seed;
   int pc;
   int wr_busy;
   int rd_busy;

   logic [31:0] rom [rom_words];
   logic [15:0] c_mem [65536];

   // Reference model state
   consolite_pkg::ctrl_state_t m_state;
   logic [15:0] m_regs [16];
   logic [15:0] m_mem [65536];
   logic [3:0]  m_flags;
   logic [3:0]  m_load_reg;

   // Expected DUT outputs as updated just after each rising edge
   logic [15:0] exp_ptr;
   logic [11:0] exp_status;
   logic        exp_wr_en;
   logic        exp_rd_en;
   logic [15:0] exp_wr_addr;
   logic [15:0] exp_wr_data;
   logic [15:0] exp_rd_addr;

   // Operand pairs for the flag and jump tests
   logic [15:0] pair_a [6] = '{16'h0005, 16'h0003, 16'h0009, 16'h8000, 16'h7fff, 16'hfffe};
   logic [15:0] pair_b [6] = '{16'h0005, 16'h0009, 16'h0003, 16'h0001, 16'hffff, 16'h0002};

   processor i_processor (
      .clk           (clk),
      .rst_n         (rst_n),
      .boot_done     (boot_done),
      .status        (status),
      .instr_ptr     (instr_ptr),
      .instr_valid   (instr_valid),
      .cur_instr     (cur_instr),
      .cache_wr_en   (cache_wr_en),
      .cache_wr_addr (cache_wr_addr),
      .cache_wr_data (cache_wr_data),
      .cache_wr_done (cache_wr_done),
      .cache_rd_en   (cache_rd_en),
      .cache_rd_addr (cache_rd_addr),
      .cache_rd_data (cache_rd_data),
      .cache_rd_done (cache_rd_done)
   );

   always #2 clk = ~clk;

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
      $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic report_error(string msg);
      $display("%s at %0t", msg, $time);
      abort_run();
   endtask

   function automatic logic [15:0] fill_word(logic [15:0] addr);
      return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
   endfunction

   // Flags {overflow, carry, zero, sign} sit above the 16-bit result
   function automatic logic [19:0] alu_model(logic [7:0] op, logic [15:0] d, logic [15:0] s);
      logic [16:0] w;
      logic        ov;
      ov = 1'b0;
      case (op)
         consolite_pkg::op_add: begin
            w  = {1'b0, d} + {1'b0, s};
            ov = (d[15] == s[15]) && (w[15] != d[15]);
         end
         consolite_pkg::op_sub, consolite_pkg::op_cmp: begin
            w  = {1'b0, d} - {1'b0, s};
            ov = (d[15] != s[15]) && (w[15] != d[15]);
         end
         consolite_pkg::op_and, consolite_pkg::op_tst: w = {1'b0, d & s};
         consolite_pkg::op_or:   w = {1'b0, d | s};
         consolite_pkg::op_xor:  w = {1'b0, d ^ s};
         consolite_pkg::op_shl:  w = {1'b0, d << s};
         consolite_pkg::op_shra: w = {1'b0, $signed(d) >>> s};
         consolite_pkg::op_shrl: w = {1'b0, d >> s};
         default:                w = '0;
      endcase
      return {ov, w[16], w[15:0] == 16'h0, w[15], w[15:0]};
   endfunction

   function automatic logic jump_taken(logic [7:0] op, logic [3:0] f);
      logic o, c, z, s;
      {o, c, z, s} = f;
      case (op)
         consolite_pkg::op_jeq: return z;
         consolite_pkg::op_jne: return !z;
         consolite_pkg::op_jg:  return !z && (s == o);
         consolite_pkg::op_jge: return s == o;
         consolite_pkg::op_ja:  return !c && !z;
         consolite_pkg::op_jae: return !c;
         consolite_pkg::op_jl:  return s != o;
         consolite_pkg::op_jle: return z || (s != o);
         consolite_pkg::op_jb:  return c;
         consolite_pkg::op_jbe: return c || z;
         consolite_pkg::op_jo:  return o;
         consolite_pkg::op_jno: return !o;
         consolite_pkg::op_js:  return s;
         consolite_pkg::op_jns: return !s;
         default:               return 1'b1;
      endcase
   endfunction

   function automatic logic [31:0] enc_rr(logic [7:0] op, logic [3:0] r1, logic [3:0] r2);
      return {op, 4'h0, r1, 4'h0, r2, 8'h00};
   endfunction

   function automatic logic [31:0] enc_ri(logic [7:0] op, logic [3:0] r1, logic [15:0] imm);
      return {op, 4'h0, r1, imm};
   endfunction

   task automatic emit(logic [31:0] instr);
      rom[pc] = instr;
      pc++;
   endtask

   // Compare or subtract, optionally a flag-clearing MOVI, then the jump
   task automatic emit_jump_case(int j, logic [15:0] a, logic [15:0] b, logic [7:0] fop,
                                 logic clear);
      emit(enc_ri(consolite_pkg::op_movi, 4, a));
      emit(enc_ri(consolite_pkg::op_movi, 5, b));
      emit(enc_rr(fop, 4, 5));
      if (clear) begin
         emit(enc_ri(consolite_pkg::op_movi, 6, 16'h0));
      end
      emit({8'(j), 16'((pc + 2) * 4), 8'h00});
      emit(enc_rr(consolite_pkg::op_nop, 0, 0));
   endtask

   task automatic build_program();
      logic [7:0]  alu_ops [8];
      logic [15:0] a;
      logic [15:0] b;
      alu_ops = '{consolite_pkg::op_add, consolite_pkg::op_sub, consolite_pkg::op_and,
                  consolite_pkg::op_or, consolite_pkg::op_xor, consolite_pkg::op_shl,
                  consolite_pkg::op_shra, consolite_pkg::op_shrl};
      pc = 0;
      // Each ALU result is stored to its own address
      for (int r = 0; r < 3; r++) begin
         a = $random(seed);
         b = (r == 0) ? 16'($random(seed)) : 16'($random(seed)) & 16'h000f;
         emit(enc_ri(consolite_pkg::op_movi, 1, a));
         emit(enc_ri(consolite_pkg::op_movi, 2, b));
         for (int k = 0; k < 8; k++) begin
            emit(enc_rr(consolite_pkg::op_mov, 3, 1));
            emit(enc_rr(alu_ops[k], 3, 2));
            emit(enc_ri(consolite_pkg::op_stori, 3, 16'(16'h1000 + r * 8 + k)));
         end
      end
      // Every conditional jump against every operand pair
      for (int j = consolite_pkg::op_jeq; j <= consolite_pkg::op_jns; j++) begin
         for (int p = 0; p < 6; p++) begin
            emit_jump_case(j, pair_a[p], pair_b[p],
                           p[0] ? consolite_pkg::op_sub : consolite_pkg::op_cmp, 1'b0);
            // Pairs 0, 1 and 3 between them set every flag
            if (p == 0 || p == 1 || p == 3) begin
               emit_jump_case(j, pair_a[p], pair_b[p], consolite_pkg::op_cmp, 1'b1);
            end
         end
      end
      // Register jump and immediate jump
      emit(enc_ri(consolite_pkg::op_movi, 7, 16'((pc + 3) * 4)));
      emit(enc_rr(consolite_pkg::op_jmp, 7, 0));
      emit(enc_rr(consolite_pkg::op_nop, 0, 0));
      emit({8'(consolite_pkg::op_jmpi), 16'((pc + 2) * 4), 8'h00});
      emit(enc_rr(consolite_pkg::op_nop, 0, 0));
      // Loads and stores through registers and immediates
      for (int r = 0; r < 6; r++) begin
         a = $random(seed);
         b = $random(seed);
         emit(enc_ri(consolite_pkg::op_loadi, 8, a));
         emit(enc_ri(consolite_pkg::op_movi, 9, b));
         emit(enc_rr(consolite_pkg::op_stor, 8, 9));
         emit(enc_rr(consolite_pkg::op_load, 10, 9));
         emit(enc_rr(consolite_pkg::op_mov, 11, 10));
         emit(enc_rr(consolite_pkg::op_add, 11, 8));
         emit(enc_ri(consolite_pkg::op_stori, 11, 16'(16'h2000 + r)));
         emit(enc_ri(consolite_pkg::op_loadi, 13, 16'(16'h1000 + r)));
         emit(enc_ri(consolite_pkg::op_stori, 13, 16'(16'h3000 + r)));
      end
      emit({8'hc3, 24'h0});
   endtask

   task automatic execute_instr();
      logic [7:0]  op;
      logic [3:0]  r1;
      logic [3:0]  r2;
      logic [15:0] d;
      logic [15:0] s;
      logic [15:0] imm;
      logic [19:0] alu_out;
      logic [15:0] next_ptr;
      op       = cur_instr[31:24];
      r1       = cur_instr[19:16];
      r2       = cur_instr[11:8];
      imm      = cur_instr[15:0];
      d        = m_regs[r1];
      s        = m_regs[r2];
      alu_out  = alu_model(op, d, s);
      next_ptr = exp_ptr + 16'd4;
      case (op)
         consolite_pkg::op_nop, consolite_pkg::op_cmp, consolite_pkg::op_tst: ;
         consolite_pkg::op_mov:  m_regs[r1] = s;
         consolite_pkg::op_movi: m_regs[r1] = imm;
         consolite_pkg::op_add, consolite_pkg::op_sub, consolite_pkg::op_and,
         consolite_pkg::op_or, consolite_pkg::op_xor, consolite_pkg::op_shl,
         consolite_pkg::op_shra, consolite_pkg::op_shrl: m_regs[r1] = alu_out[15:0];
         consolite_pkg::op_stor, consolite_pkg::op_stori: begin
            if (cache_wr_done) begin
               exp_wr_en   = 1'b1;
               exp_wr_addr = (op == consolite_pkg::op_stori) ? imm : s;
               exp_wr_data = d;
               m_mem[exp_wr_addr] = d;
               m_state = consolite_pkg::st_wr_wait;
            end else begin
               next_ptr = exp_ptr;
            end
         end
         consolite_pkg::op_load, consolite_pkg::op_loadi: begin
            if (cache_rd_done) begin
               exp_rd_en   = 1'b1;
               exp_rd_addr = (op == consolite_pkg::op_loadi) ? imm : s;
               m_load_reg  = r1;
               m_state     = consolite_pkg::st_rd_wait;
            end else begin
               next_ptr = exp_ptr;
            end
         end
         consolite_pkg::op_jmp: next_ptr = d;
         consolite_pkg::op_jmpi, consolite_pkg::op_jeq, consolite_pkg::op_jne,
         consolite_pkg::op_jg, consolite_pkg::op_jge, consolite_pkg::op_ja,
         consolite_pkg::op_jae, consolite_pkg::op_jl, consolite_pkg::op_jle,
         consolite_pkg::op_jb, consolite_pkg::op_jbe, consolite_pkg::op_jo,
         consolite_pkg::op_jno, consolite_pkg::op_js, consolite_pkg::op_jns: begin
            if (jump_taken(op, m_flags)) begin
               next_ptr = cur_instr[23:8];
            end
         end
         default: begin
            exp_status = consolite_pkg::status_invalid_base | {4'h0, op};
            m_state    = consolite_pkg::st_halt;
            next_ptr   = exp_ptr;
         end
      endcase
      if (op == consolite_pkg::op_add || op == consolite_pkg::op_sub ||
          op == consolite_pkg::op_cmp || op == consolite_pkg::op_tst) begin
         m_flags = alu_out[19:16];
      end else begin
         m_flags = 4'h0;
      end
      exp_ptr = next_ptr;
   endtask

   // Advance the reference model by the edge that just passed
   task automatic model_step();
      exp_wr_en = 1'b0;
      exp_rd_en = 1'b0;
      case (m_state)
         consolite_pkg::st_pre_boot: begin
            if (boot_done) begin
               m_state = consolite_pkg::st_executing;
            end
         end
         consolite_pkg::st_executing: begin
            if (instr_valid) begin
               execute_instr();
            end
         end
         consolite_pkg::st_wr_wait: begin
            if (cache_wr_done) begin
               m_state = consolite_pkg::st_executing;
            end
         end
         consolite_pkg::st_rd_wait: begin
            if (cache_rd_done) begin
               m_regs[m_load_reg] = m_mem[exp_rd_addr];
               m_state = consolite_pkg::st_executing;
            end
         end
         default: ;
      endcase
   endtask

   // Data cache model with 1 to 4 busy cycles per access and random busy cycles when idle
   task automatic cache_step();
      if (cache_wr_en) begin
         c_mem[cache_wr_addr] = cache_wr_data;
         wr_busy       = 1 + {$random(seed)} % 4;
         cache_wr_done = 1'b0;
      end else if (wr_busy > 0) begin
         wr_busy       = wr_busy - 1;
         cache_wr_done = (wr_busy == 0);
      end else begin
         cache_wr_done = ($random(seed) % 6) != 0;
      end
      if (cache_rd_en) begin
         cache_rd_data = c_mem[cache_rd_addr];
         rd_busy       = 1 + {$random(seed)} % 4;
         cache_rd_done = 1'b0;
      end else if (rd_busy > 0) begin
         rd_busy       = rd_busy - 1;
         cache_rd_done = (rd_busy == 0);
      end else begin
         cache_rd_done = ($random(seed) % 6) != 0;
      end
   endtask

   task automatic run_cycle(int cycle);
      @(posedge clk);
      #1;
      model_step();
      cache_step();
      boot_done   = (cycle >= 2);
      instr_valid = ($random(seed) % 4) != 0;
      cur_instr   = rom[instr_ptr[11:2]];
   endtask

   // Expected values stay at their reset state until the model runs
   a_ptr: assert property (@(posedge clk) instr_ptr == exp_ptr)
      else report_mismatch("instr_ptr", $sampled(exp_ptr), $sampled(instr_ptr));
   a_status: assert property (@(posedge clk) status == exp_status)
      else report_mismatch("status", $sampled(exp_status), $sampled(status));
   a_wr_en: assert property (@(posedge clk) cache_wr_en == exp_wr_en)
      else report_mismatch("cache_wr_en", $sampled(exp_wr_en), $sampled(cache_wr_en));
   a_rd_en: assert property (@(posedge clk) cache_rd_en == exp_rd_en)
      else report_mismatch("cache_rd_en", $sampled(exp_rd_en), $sampled(cache_rd_en));
   a_wr_addr: assert property (@(posedge clk) cache_wr_en |-> cache_wr_addr == exp_wr_addr)
      else report_mismatch("cache_wr_addr", $sampled(exp_wr_addr), $sampled(cache_wr_addr));
   a_wr_data: assert property (@(posedge clk) cache_wr_en |-> cache_wr_data == exp_wr_data)
      else report_mismatch("cache_wr_data", $sampled(exp_wr_data), $sampled(cache_wr_data));
   a_rd_addr: assert property (@(posedge clk) cache_rd_en |-> cache_rd_addr == exp_rd_addr)
      else report_mismatch("cache_rd_addr", $sampled(exp_rd_addr), $sampled(cache_rd_addr));
   a_wr_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      cache_wr_en |-> $past(cache_wr_done))
      else report_error("Write strobe issued while the cache was busy");
   a_rd_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      cache_rd_en |-> $past(cache_rd_done))
      else report_error("Read strobe issued while the cache was busy");

   initial begin
      int cycle;
      seed          = 12123;
      clk           = 1'b0;
      rst_n         = 1'b1;
      boot_done     = 1'b0;
      instr_valid   = 1'b0;
      cur_instr     = '0;
      cache_wr_done = 1'b1;
      cache_rd_done = 1'b1;
      cache_rd_data = '0;
      wr_busy       = 0;
      rd_busy       = 0;
      m_state       = consolite_pkg::st_pre_boot;
      m_flags       = '0;
      m_load_reg    = '0;
      exp_ptr       = '0;
      exp_status    = '0;
      exp_wr_en     = 1'b0;
      exp_rd_en     = 1'b0;
      exp_wr_addr   = '0;
      exp_wr_data   = '0;
      exp_rd_addr   = '0;
      for (int i = 0; i < 65536; i++) begin
         c_mem[i] = fill_word(16'(i));
         m_mem[i] = fill_word(16'(i));
      end
      for (int i = 0; i < 16; i++) begin
         m_regs[i] = '0;
      end
      for (int i = 0; i < rom_words; i++) begin
         rom[i] = '0;
      end
      build_program();
      #1 rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      cycle = 0;
      while (m_state != consolite_pkg::st_halt && cycle < max_cycles) begin
         run_cycle(cycle);
         cycle++;
      end
      if (m_state == consolite_pkg::st_halt) begin
         // Halted core must keep still
         for (int i = 0; i < 12; i++) begin
            run_cycle(cycle + i);
         end
         $display("Simulation passed");
         $finish;
      end else begin
         $display("Processor did not halt within %0d cycles", max_cycles);
         abort_run();
      end
   end

endmodule

// File: filelist.f
consolite_pkg.sv
register_file.sv
alu.sv
flag_unit.sv
control_unit.sv
processor.sv
tb_processor.sv

// File: Bender.yml
package:
  name: consolite_core

sources:
  - consolite_pkg.sv
  - register_file.sv
  - alu.sv
  - flag_unit.sv
  - control_unit.sv
  - processor.sv
  - target: simulation
    files:
      - tb_processor.sv
